/* verilog/regFilePkg.sv */
// Shared definitions for the banked register file read path
// Operand count per dispatch and the collector FSM states

package regFilePkg;

    // ########################################################################
    // Operand count
    // ########################################################################

    // Source operands delivered with every dispatch
    // Index 0 is operand A, index 1 is operand B
    localparam int unsigned NumOperands = 2;

    // ########################################################################
    // Collector FSM
    // ########################################################################

    // Idle waits for a dispatch
    // Collect has requests or reads still open
    // Result presents both operands for a single cycle
    typedef enum logic [1:0] {
        Idle    = 2'd0,
        Collect = 2'd1,
        Result  = 2'd2
    } collectorState_e;

endpackage : regFilePkg

/* verilog/registerIndexer.sv */
// Register indexer
// Maps a warp id and register index to a bank select and in-bank address
// Elaboration check against aliasing width combinations

module registerIndexer #(
    parameter int unsigned NumWarps         = 2,
    parameter int unsigned RegIdxWidth      = 6,
    parameter int unsigned NumBanks         = 4,
    parameter int unsigned RegistersPerBank = 32,
    // Derived widths
    localparam int unsigned WidWidth         = NumWarps > 1 ? $clog2(NumWarps) : 1,
    localparam int unsigned BankSelWidth     = NumBanks > 1 ? $clog2(NumBanks) : 1,
    localparam int unsigned BankRegAddrWidth =
        RegistersPerBank > 1 ? $clog2(RegistersPerBank) : 1
) (
    input  logic [WidWidth-1:0]         wid_i,
    input  logic [RegIdxWidth-1:0]      regIdx_i,
    output logic [BankSelWidth-1:0]     bankSel_o,
    output logic [BankRegAddrWidth-1:0] bankRegAddr_o
);

    // Warp bits above register bits
    localparam int unsigned HashWidth = WidWidth + RegIdxWidth;

    // Bits that really carry information, the warp bit is a dummy with one warp
    localparam int unsigned UsedWidth   = NumWarps > 1 ? HashWidth : RegIdxWidth;
    localparam int unsigned MappedWidth =
        NumBanks > 1 ? BankSelWidth + BankRegAddrWidth : BankRegAddrWidth;

    logic [HashWidth-1:0] hash;

    assign hash = {wid_i, regIdx_i};

    // ########################################################################
    // Bank select from the top bits
    // ########################################################################

    if (NumBanks > 1) begin : genMultiBank
        if (NumWarps > 1) begin : genMultiWarp
            // Warp bit first, then the top register bits
            assign bankSel_o = hash[HashWidth-1 -: BankSelWidth];
        end else begin : genSingleWarp
            // Only the register index spreads over the banks
            assign bankSel_o = hash[RegIdxWidth-1 -: BankSelWidth];
        end
    end else begin : genSingleBank
        assign bankSel_o = '0;
    end

    // In-bank address from the low bits
    assign bankRegAddr_o = hash[BankRegAddrWidth-1:0];

    // Index space must match bank space exactly, else registers alias
    if (UsedWidth != MappedWidth) begin : genWidthError
        $error("registerIndexer: %0d index bits do not fit %0d bank bits",
               UsedWidth, MappedWidth);
    end

endmodule : registerIndexer

/* verilog/registerBank.sv */
// Register bank
// One synchronous read port and one write port
// Read returns the old contents on a same-edge write

module registerBank #(
    parameter int unsigned RegistersPerBank = 32,
    parameter int unsigned DataWidth        = 32,
    parameter int unsigned NumBanks         = 4,
    parameter int unsigned BankIndex        = 0,
    localparam int unsigned BankSelWidth     = NumBanks > 1 ? $clog2(NumBanks) : 1,
    localparam int unsigned BankRegAddrWidth =
        RegistersPerBank > 1 ? $clog2(RegistersPerBank) : 1
) (
    input  logic                        clk_i,
    input  logic                        rstN_i,
    input  logic                        readEn_i,
    input  logic [BankRegAddrWidth-1:0] readAddr_i,
    output logic [DataWidth-1:0]        readData_o,
    input  logic                        writeEn_i,
    input  logic [BankSelWidth-1:0]     writeBankSel_i,
    input  logic [BankRegAddrWidth-1:0] writeAddr_i,
    input  logic [DataWidth-1:0]        writeData_i
);

    logic [DataWidth-1:0] mem [RegistersPerBank];
    logic                 writeHit;

    // Common write bus, this bank takes only its own select
    assign writeHit = writeEn_i && (writeBankSel_i == BankSelWidth'(BankIndex));

    always_ff @(posedge clk_i) begin
        if (writeHit) begin
            mem[writeAddr_i] <= writeData_i;
        end
    end

    // Read register samples the array before this edge's write lands
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            readData_o <= '0;
        end else if (readEn_i) begin
            readData_o <= mem[readAddr_i];
        end
    end

endmodule : registerBank

/* verilog/bankCrossbar.sv */
// Bank crossbar
// Fixed-priority read arbitration per bank, lowest operand wins
// Return routing of bank read data one cycle after the grant

module bankCrossbar #(
    parameter int unsigned NumBanks         = 4,
    parameter int unsigned RegistersPerBank = 32,
    parameter int unsigned DataWidth        = 32,
    localparam int unsigned NumOps           = regFilePkg::NumOperands,
    localparam int unsigned BankSelWidth     = NumBanks > 1 ? $clog2(NumBanks) : 1,
    localparam int unsigned BankRegAddrWidth =
        RegistersPerBank > 1 ? $clog2(RegistersPerBank) : 1
) (
    input  logic                                       clk_i,
    input  logic                                       rstN_i,
    // Operand side
    input  logic [NumOps-1:0]                          reqValid_i,
    input  logic [NumOps-1:0][BankSelWidth-1:0]        reqBankSel_i,
    input  logic [NumOps-1:0][BankRegAddrWidth-1:0]    reqBankAddr_i,
    output logic [NumOps-1:0]                          reqGrant_o,
    output logic [NumOps-1:0]                          rspValid_o,
    output logic [NumOps-1:0][DataWidth-1:0]           rspData_o,
    // Bank side
    output logic [NumBanks-1:0]                        bankReadEn_o,
    output logic [NumBanks-1:0][BankRegAddrWidth-1:0]  bankReadAddr_o,
    input  logic [NumBanks-1:0][DataWidth-1:0]         bankReadData_i
);

    // Bank each granted operand read from
    logic [NumOps-1:0][BankSelWidth-1:0] rspBankQ;

    // ########################################################################
    // Arbitration
    // ########################################################################

    // Walk operands upward, the first requester claims the bank
    // A claimed bank refuses later operands this cycle
    always_comb begin
        bankReadEn_o   = '0;
        bankReadAddr_o = '0;
        reqGrant_o     = '0;
        for (int b = 0; b < NumBanks; b++) begin
            for (int op = 0; op < NumOps; op++) begin
                if (reqValid_i[op] && !bankReadEn_o[b] &&
                    reqBankSel_i[op] == BankSelWidth'(b)) begin
                    bankReadEn_o[b]   = 1'b1;
                    bankReadAddr_o[b] = reqBankAddr_i[op];
                    reqGrant_o[op]    = 1'b1;
                end
            end
        end
    end

    // ########################################################################
    // Response routing
    // ########################################################################

    // Response valid trails the grant by one cycle, same as the bank read
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rspValid_o <= '0;
        end else begin
            rspValid_o <= reqGrant_o;
        end
    end

    // Remember the source bank for the data mux
    always_ff @(posedge clk_i) begin
        for (int op = 0; op < NumOps; op++) begin
            if (reqGrant_o[op]) begin
                rspBankQ[op] <= reqBankSel_i[op];
            end
        end
    end

    for (genvar op = 0; op < NumOps; op++) begin : genRspMux
        assign rspData_o[op] = bankReadData_i[rspBankQ[op]];
    end

endmodule : bankCrossbar

/* verilog/operandCollector.sv */
// Operand collector
// Captures a dispatch and maps both source registers to banks
// Holds requests until granted, captures returned data
// Presents both operands together for one cycle

module operandCollector #(
    parameter int unsigned NumWarps         = 2,
    parameter int unsigned RegIdxWidth      = 6,
    parameter int unsigned NumBanks         = 4,
    parameter int unsigned RegistersPerBank = 32,
    parameter int unsigned DataWidth        = 32,
    localparam int unsigned NumOps           = regFilePkg::NumOperands,
    localparam int unsigned WidWidth         = NumWarps > 1 ? $clog2(NumWarps) : 1,
    localparam int unsigned BankSelWidth     = NumBanks > 1 ? $clog2(NumBanks) : 1,
    localparam int unsigned BankRegAddrWidth =
        RegistersPerBank > 1 ? $clog2(RegistersPerBank) : 1
) (
    input  logic                                    clk_i,
    input  logic                                    rstN_i,
    // Dispatch
    input  logic                                    dispatch_i,
    input  logic [WidWidth-1:0]                     dispatchWid_i,
    input  logic [RegIdxWidth-1:0]                  dispatchRegIdxA_i,
    input  logic [RegIdxWidth-1:0]                  dispatchRegIdxB_i,
    output logic                                    busy_o,
    // Crossbar requests and responses
    output logic [NumOps-1:0]                       reqValid_o,
    output logic [NumOps-1:0][BankSelWidth-1:0]     reqBankSel_o,
    output logic [NumOps-1:0][BankRegAddrWidth-1:0] reqBankAddr_o,
    input  logic [NumOps-1:0]                       reqGrant_i,
    input  logic [NumOps-1:0]                       rspValid_i,
    input  logic [NumOps-1:0][DataWidth-1:0]        rspData_i,
    // Result
    output logic                                    operandsValid_o,
    output logic [WidWidth-1:0]                     resultWid_o,
    output logic [DataWidth-1:0]                    operandA_o,
    output logic [DataWidth-1:0]                    operandB_o
);

    regFilePkg::collectorState_e stateQ, stateD;

    // Requests not yet granted
    logic [NumOps-1:0] pendingQ, pendingD;
    // Operands whose data has arrived
    logic [NumOps-1:0] capturedQ, capturedD;
    logic              accept;

    logic [NumOps-1:0][RegIdxWidth-1:0]      dispatchRegIdx;
    logic [NumOps-1:0][BankSelWidth-1:0]     idxBankSel;
    logic [NumOps-1:0][BankRegAddrWidth-1:0] idxBankAddr;
    logic [NumOps-1:0][DataWidth-1:0]        operandQ;

    // ########################################################################
    // Index mapping, one indexer per source operand
    // ########################################################################

    assign dispatchRegIdx[0] = dispatchRegIdxA_i;
    assign dispatchRegIdx[1] = dispatchRegIdxB_i;

    for (genvar op = 0; op < NumOps; op++) begin : genIndexer
        registerIndexer #(
            .NumWarps        (NumWarps),
            .RegIdxWidth     (RegIdxWidth),
            .NumBanks        (NumBanks),
            .RegistersPerBank(RegistersPerBank)
        ) indexer (
            .wid_i        (dispatchWid_i),
            .regIdx_i     (dispatchRegIdx[op]),
            .bankSel_o    (idxBankSel[op]),
            .bankRegAddr_o(idxBankAddr[op])
        );
    end

    // ########################################################################
    // FSM
    // ########################################################################

    // Dispatch only counts while idle
    assign accept = dispatch_i && (stateQ == regFilePkg::Idle);

    always_comb begin
        stateD    = stateQ;
        pendingD  = pendingQ & ~reqGrant_i;
        capturedD = capturedQ | rspValid_i;
        case (stateQ)
            regFilePkg::Idle: begin
                if (dispatch_i) begin
                    stateD    = regFilePkg::Collect;
                    pendingD  = '1;
                    capturedD = '0;
                end
            end
            // Leave once the last response lands this cycle
            regFilePkg::Collect: begin
                if (&capturedD) begin
                    stateD = regFilePkg::Result;
                end
            end
            regFilePkg::Result: begin
                stateD = regFilePkg::Idle;
            end
            default: begin
                stateD = regFilePkg::Idle;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            stateQ    <= regFilePkg::Idle;
            pendingQ  <= '0;
            capturedQ <= '0;
        end else begin
            stateQ    <= stateD;
            pendingQ  <= pendingD;
            capturedQ <= capturedD;
        end
    end

    // Dispatch payload and returned operand data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            resultWid_o   <= dispatchWid_i;
            reqBankSel_o  <= idxBankSel;
            reqBankAddr_o <= idxBankAddr;
        end
        for (int op = 0; op < NumOps; op++) begin
            if (rspValid_i[op]) begin
                operandQ[op] <= rspData_i[op];
            end
        end
    end

    // Requests stay up until granted
    assign reqValid_o      = pendingQ;
    assign busy_o          = stateQ != regFilePkg::Idle;
    assign operandsValid_o = stateQ == regFilePkg::Result;
    assign operandA_o      = operandQ[0];
    assign operandB_o      = operandQ[1];

endmodule : operandCollector

/* verilog/registerFile.sv */
// Banked register file operand read path, top level
// Operand collector, bank crossbar, writeback indexer and the banks

module registerFile #(
    parameter int unsigned NumWarps         = 2,
    parameter int unsigned RegIdxWidth      = 6,
    parameter int unsigned NumBanks         = 4,
    parameter int unsigned RegistersPerBank = 32,
    parameter int unsigned DataWidth        = 32,
    localparam int unsigned WidWidth         = NumWarps > 1 ? $clog2(NumWarps) : 1,
    localparam int unsigned BankSelWidth     = NumBanks > 1 ? $clog2(NumBanks) : 1,
    localparam int unsigned BankRegAddrWidth =
        RegistersPerBank > 1 ? $clog2(RegistersPerBank) : 1
) (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    // Dispatch
    input  logic                   dispatch_i,
    input  logic [WidWidth-1:0]    dispatchWid_i,
    input  logic [RegIdxWidth-1:0] dispatchRegIdxA_i,
    input  logic [RegIdxWidth-1:0] dispatchRegIdxB_i,
    output logic                   busy_o,
    // Result
    output logic                   operandsValid_o,
    output logic [WidWidth-1:0]    resultWid_o,
    output logic [DataWidth-1:0]   operandA_o,
    output logic [DataWidth-1:0]   operandB_o,
    // Writeback
    input  logic                   writeEn_i,
    input  logic [WidWidth-1:0]    writeWid_i,
    input  logic [RegIdxWidth-1:0] writeRegIdx_i,
    input  logic [DataWidth-1:0]   writeData_i
);

    localparam int unsigned NumOps = regFilePkg::NumOperands;

    // Collector to crossbar
    logic [NumOps-1:0]                       reqValid;
    logic [NumOps-1:0][BankSelWidth-1:0]     reqBankSel;
    logic [NumOps-1:0][BankRegAddrWidth-1:0] reqBankAddr;
    logic [NumOps-1:0]                       reqGrant;
    logic [NumOps-1:0]                       rspValid;
    logic [NumOps-1:0][DataWidth-1:0]        rspData;

    // Crossbar to banks
    logic [NumBanks-1:0]                        bankReadEn;
    logic [NumBanks-1:0][BankRegAddrWidth-1:0]  bankReadAddr;
    logic [NumBanks-1:0][DataWidth-1:0]         bankReadData;

    // Writeback mapping, shared by all banks
    logic [BankSelWidth-1:0]     writeBankSel;
    logic [BankRegAddrWidth-1:0] writeBankAddr;

    operandCollector #(
        .NumWarps(NumWarps), .RegIdxWidth(RegIdxWidth), .NumBanks(NumBanks),
        .RegistersPerBank(RegistersPerBank), .DataWidth(DataWidth)
    ) collector (
        .clk_i, .rstN_i,
        .dispatch_i, .dispatchWid_i, .dispatchRegIdxA_i, .dispatchRegIdxB_i, .busy_o,
        .reqValid_o(reqValid), .reqBankSel_o(reqBankSel), .reqBankAddr_o(reqBankAddr),
        .reqGrant_i(reqGrant), .rspValid_i(rspValid), .rspData_i(rspData),
        .operandsValid_o, .resultWid_o, .operandA_o, .operandB_o
    );

    bankCrossbar #(
        .NumBanks(NumBanks), .RegistersPerBank(RegistersPerBank), .DataWidth(DataWidth)
    ) crossbar (
        .clk_i, .rstN_i,
        .reqValid_i(reqValid), .reqBankSel_i(reqBankSel), .reqBankAddr_i(reqBankAddr),
        .reqGrant_o(reqGrant), .rspValid_o(rspValid), .rspData_o(rspData),
        .bankReadEn_o(bankReadEn), .bankReadAddr_o(bankReadAddr),
        .bankReadData_i(bankReadData)
    );

    // Same mapping as the read side, so writes land where reads look
    registerIndexer #(
        .NumWarps(NumWarps), .RegIdxWidth(RegIdxWidth), .NumBanks(NumBanks),
        .RegistersPerBank(RegistersPerBank)
    ) writeIndexer (
        .wid_i(writeWid_i), .regIdx_i(writeRegIdx_i),
        .bankSel_o(writeBankSel), .bankRegAddr_o(writeBankAddr)
    );

    // Each bank filters the write bus by its own index
    for (genvar b = 0; b < NumBanks; b++) begin : genBank
        registerBank #(
            .RegistersPerBank(RegistersPerBank), .DataWidth(DataWidth),
            .NumBanks(NumBanks), .BankIndex(b)
        ) bank (
            .clk_i, .rstN_i,
            .readEn_i(bankReadEn[b]), .readAddr_i(bankReadAddr[b]),
            .readData_o(bankReadData[b]),
            .writeEn_i, .writeBankSel_i(writeBankSel), .writeAddr_i(writeBankAddr),
            .writeData_i
        );
    end

endmodule : registerFile

/* bench/registerFileSva.sv */
// Concurrent protocol checks for the register file read path
// Quiet start after reset, result latency per bank conflict, return to idle

module registerFileSva #(
    parameter int unsigned NumWarps    = 2,
    parameter int unsigned RegIdxWidth = 6,
    localparam int unsigned WidWidth   = NumWarps > 1 ? $clog2(NumWarps) : 1
) (
    input logic                        clk_i,
    input logic                        rstN_i,
    input logic                        dispatch_i,
    input logic [WidWidth-1:0]         dispatchWid_i,
    input logic [RegIdxWidth-1:0]      dispatchRegIdxA_i,
    input logic [RegIdxWidth-1:0]      dispatchRegIdxB_i,
    input logic                        busy_i,
    input logic                        operandsValid_i,
    input regFilePkg::collectorState_e collectorState_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic                accept;
    logic                conflict;
    logic                dispatchSeen;
    // Bank is the warp bit followed by the top register bit
    logic [WidWidth:0]   bankA;
    logic [WidWidth:0]   bankB;
    // Number of failed assertions so far
    int                  failCount = 0;

    assign accept   = dispatch_i && !busy_i;
    assign bankA    = {dispatchWid_i, dispatchRegIdxA_i[RegIdxWidth-1]};
    assign bankB    = {dispatchWid_i, dispatchRegIdxB_i[RegIdxWidth-1]};
    assign conflict = bankA == bankB;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            dispatchSeen <= 1'b0;
        end else if (accept) begin
            dispatchSeen <= 1'b1;
        end
    end

    // ########################################################################
    // Assertions
    // ########################################################################

    // Nothing moves before the first accepted dispatch
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        !dispatchSeen |-> !busy_i && !operandsValid_i)
        else begin
            $error("Busy or result seen before the first dispatch");
            failCount++;
        end

    // Separate banks, one pulse two cycles after the dispatch edge
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        accept && !conflict |=>
            !operandsValid_i ##1 !operandsValid_i ##1 operandsValid_i ##1 !operandsValid_i)
        else begin
            $error("Conflict-free dispatch did not give a single pulse after 2 cycles");
            failCount++;
        end

    // Same bank, the second read waits one cycle
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        accept && conflict |=>
            !operandsValid_i ##1 !operandsValid_i ##1 !operandsValid_i ##1
            operandsValid_i ##1 !operandsValid_i)
        else begin
            $error("Conflicting dispatch did not give a single pulse after 3 cycles");
            failCount++;
        end

    // Busy drops and the FSM is back in Idle right after the pulse
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        operandsValid_i |=> !busy_i && collectorState_i == regFilePkg::Idle)
        else begin
            $error("Busy or collector state did not return to idle after the result");
            failCount++;
        end

endmodule : registerFileSva

bind registerFile registerFileSva #(
    .NumWarps(NumWarps), .RegIdxWidth(RegIdxWidth)
) sva (
    .clk_i(clk_i), .rstN_i(rstN_i), .dispatch_i(dispatch_i),
    .dispatchWid_i(dispatchWid_i), .dispatchRegIdxA_i(dispatchRegIdxA_i),
    .dispatchRegIdxB_i(dispatchRegIdxB_i), .busy_i(busy_o),
    .operandsValid_i(operandsValid_o), .collectorState_i(collector.stateQ)
);

/* bench/registerFileTb.sv */
// Testbench for the banked register file read path
// Clock, reset, xorshift stimulus, shadow register model and data checks
// Watchdog and closing summary

module registerFileTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned NumWarps         = 2;
    localparam int unsigned RegIdxWidth      = 6;
    localparam int unsigned NumBanks         = 4;
    localparam int unsigned RegistersPerBank = 32;
    localparam int unsigned DataWidth        = 32;
    localparam int unsigned WidWidth         = NumWarps > 1 ? $clog2(NumWarps) : 1;
    localparam int unsigned NumRegs          = 1 << RegIdxWidth;
    localparam int unsigned NumDispatches    = 200;
    // Fill, worst-case dispatch length, then margin for reset
    localparam int unsigned WatchdogCycles   = NumWarps * NumRegs + NumDispatches * 5 + 50;

    logic                   clk;
    logic                   rstN_i;
    logic                   dispatch_i;
    logic [WidWidth-1:0]    dispatchWid_i;
    logic [RegIdxWidth-1:0] dispatchRegIdxA_i;
    logic [RegIdxWidth-1:0] dispatchRegIdxB_i;
    logic                   busy_o;
    logic                   operandsValid_o;
    logic [WidWidth-1:0]    resultWid_o;
    logic [DataWidth-1:0]   operandA_o;
    logic [DataWidth-1:0]   operandB_o;
    logic                   writeEn_i;
    logic [WidWidth-1:0]    writeWid_i;
    logic [RegIdxWidth-1:0] writeRegIdx_i;
    logic [DataWidth-1:0]   writeData_i;

    // Expected contents of every register
    logic [DataWidth-1:0] shadow [NumWarps][NumRegs];
    logic [31:0]          rngState;
    int                   errorCount;
    int                   acceptedCount;
    int                   pulseCount;

    registerFile #(
        .NumWarps(NumWarps), .RegIdxWidth(RegIdxWidth), .NumBanks(NumBanks),
        .RegistersPerBank(RegistersPerBank), .DataWidth(DataWidth)
    ) UUT (.*, .clk_i(clk));

    always #5 clk = ~clk;

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (operandsValid_o) begin
            pulseCount++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
            errorCount++;
        end
    endtask

    // One write cycle, shadow follows the DUT
    task automatic writeRegister(input logic [WidWidth-1:0] wid,
                                 input logic [RegIdxWidth-1:0] regIdx,
                                 input logic [DataWidth-1:0] data);
        @(negedge clk);
        while (busy_o) @(negedge clk);
        writeEn_i     = 1'b1;
        writeWid_i    = wid;
        writeRegIdx_i = regIdx;
        writeData_i   = data;
        shadow[wid][regIdx] = data;
    endtask

    // ########################################################################
    // Dispatch, a stray dispatch while busy, then the result checks
    // ########################################################################

    task automatic runDispatch(input logic [WidWidth-1:0] wid,
                               input logic [RegIdxWidth-1:0] regA,
                               input logic [RegIdxWidth-1:0] regB,
                               input logic rewrite, input logic [DataWidth-1:0] newData);
        logic [DataWidth-1:0] expA;
        logic [DataWidth-1:0] expB;
        @(negedge clk);
        while (busy_o) @(negedge clk);
        // Write on the dispatch edge, visible to the first grant
        if (rewrite) begin
            writeEn_i     = 1'b1;
            writeWid_i    = wid;
            writeRegIdx_i = regA;
            writeData_i   = newData;
            shadow[wid][regA] = newData;
        end
        expA              = shadow[wid][regA];
        expB              = shadow[wid][regB];
        dispatch_i        = 1'b1;
        dispatchWid_i     = wid;
        dispatchRegIdxA_i = regA;
        dispatchRegIdxB_i = regB;
        acceptedCount++;
        @(negedge clk);
        writeEn_i         = 1'b0;
        // Held strobe with other operands, must be dropped
        dispatchWid_i     = ~wid;
        dispatchRegIdxA_i = ~regA;
        dispatchRegIdxB_i = ~regB;
        @(negedge clk);
        dispatch_i = 1'b0;
        while (!operandsValid_o) @(negedge clk);
        checkValue(rewrite ? "rewrite" : "readA", expA, operandA_o);
        checkValue("readB", expB, operandB_o);
        checkValue("wid", 32'(wid), 32'(resultWid_o));
    endtask

    initial begin
        logic [WidWidth-1:0]    wid;
        logic [RegIdxWidth-1:0] regA;
        logic [RegIdxWidth-1:0] regB;
        logic                   rewrite;
        clk = 1'b0;
        rstN_i = 1'b0;
        dispatch_i = 1'b0;
        dispatchWid_i = '0;
        dispatchRegIdxA_i = '0;
        dispatchRegIdxB_i = '0;
        writeEn_i = 1'b0;
        writeWid_i = '0;
        writeRegIdx_i = '0;
        writeData_i = '0;
        rngState = 32'h7de5d9e3;
        errorCount = 0;
        acceptedCount = 0;
        pulseCount = 0;
        repeat (3) @(negedge clk);
        rstN_i = 1'b1;

        // Fill every register of every warp
        for (int w = 0; w < NumWarps; w++) begin
            for (int r = 0; r < NumRegs; r++) begin
                rngState = xorshift32(rngState);
                writeRegister(WidWidth'(w), RegIdxWidth'(r), rngState);
            end
        end
        @(negedge clk);
        writeEn_i = 1'b0;

        for (int n = 0; n < NumDispatches; n++) begin
            rngState = xorshift32(rngState);
            wid  = rngState[WidWidth-1:0];
            regA = rngState[13:8];
            regB = rngState[21:16];
            // Same register on both operands now and then
            if (n % 16 == 5) begin
                regB = regA;
            end
            rewrite  = (n % 4 == 3);
            rngState = xorshift32(rngState);
            runDispatch(wid, regA, regB, rewrite, rngState);
        end

        // Let the last pulse be counted
        @(negedge clk);
        checkValue("pulses", acceptedCount, pulseCount);
        $display("Summary: %0d errors, %0d SVA failures, %0d dispatches, %0d pulses",
                 errorCount, UUT.sva.failCount, acceptedCount, pulseCount);
        if (errorCount == 0 && UUT.sva.failCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired, the result pulses stopped arriving in time");
        $display("Testbench failed");
        $finish;
    end

endmodule : registerFileTb

/* src.f */
verilog/regFilePkg.sv
verilog/registerIndexer.sv
verilog/registerBank.sv
verilog/bankCrossbar.sv
verilog/operandCollector.sv
verilog/registerFile.sv
bench/registerFileSva.sv
bench/registerFileTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -j 0 -f src.f --top-module registerFileTb -Mdir obj_dir

./obj_dir/VregisterFileTb | tee sim.log

# Pass only when the testbench reported it
grep -q "Testbench passed" sim.log
